/* source/cpu_types_pkg.sv */
package cpu_types_pkg;

	// debug tag carried from execute to writeback
	localparam int TAG_WIDTH = 8;

	// access width in bytes, same encoding as the execute stage
	typedef enum logic [2:0] {
		MEM_BYTE = 3'd1,
		MEM_HALF = 3'd2,
		MEM_WORD = 3'd4
	} mem_width_t;

	// memory stage FSM
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_WORD,
		ST_WRITE_RMW_READ,
		ST_WRITE_RMW_WRITE,
		ST_FLUSH
	} mem_state_t;

endpackage

/* source/cache_types_pkg.sv */
package cache_types_pkg;

	// one 32-bit word per line
	localparam int WORD_OFFSET_BITS = 2;
	localparam int MAX_TAG_WIDTH = 32 - WORD_OFFSET_BITS;

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_LOOKUP,
		CS_EVICT,
		CS_FILL,
		CS_RESPOND,
		CS_FLUSH_SCAN,
		CS_FLUSH_WRITE
	} cache_state_t;

	// tag field sized for the smallest cache, upper bits stay zero
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [MAX_TAG_WIDTH-1:0] tag;
	} line_meta_t;

endpackage

/* source/dcache_if.sv */
`timescale 1ns/1ps

interface dcache_if;

	logic request;
	logic rw;
	logic flush;
	logic [31:0] address;
	logic [31:0] wdata;
	logic ready;
	logic [31:0] rdata;

	// memory stage side
	modport stage (
		output request, rw, flush, address, wdata,
		input ready, rdata
	);

	// data cache side
	modport cache (
		input request, rw, flush, address, wdata,
		output ready, rdata
	);

endinterface

/* source/data_cache.sv */
`timescale 1ns/1ps

module data_cache #(
	parameter int CACHE_LINES = 16
) (
	input logic i_clock,
	input logic i_reset,

	dcache_if.cache dcache,

	output logic o_bus_rw,
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata,
	output logic [31:0] o_bus_wdata
);

	import cache_types_pkg::*;

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int TAG_BITS = MAX_TAG_WIDTH - INDEX_BITS;
	localparam logic [INDEX_BITS-1:0] LAST_LINE = INDEX_BITS'(CACHE_LINES - 1);

	logic [31:0] data_array [CACHE_LINES];
	line_meta_t meta_array [CACHE_LINES];

	cache_state_t state;

	// latched request, word address only
	logic [MAX_TAG_WIDTH-1:0] req_word;
	logic req_rw;
	logic [31:0] req_wdata;
	logic [31:0] rdata_q;
	logic [INDEX_BITS-1:0] scan_index;

	logic [INDEX_BITS-1:0] line_index;
	logic [TAG_BITS-1:0] req_tag;
	line_meta_t line_meta;
	line_meta_t scan_meta;
	logic hit;
	logic scan_last;

	assign line_index = req_word[INDEX_BITS-1:0];
	assign req_tag = req_word[MAX_TAG_WIDTH-1:INDEX_BITS];
	assign line_meta = meta_array[line_index];
	assign scan_meta = meta_array[scan_index];
	assign hit = line_meta.valid && (line_meta.tag[TAG_BITS-1:0] == req_tag);
	assign scan_last = (scan_index == LAST_LINE);

	assign dcache.ready = (state == CS_RESPOND);
	assign dcache.rdata = rdata_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CS_IDLE;
			o_bus_request <= 1'b0;
			for (int i = 0; i < CACHE_LINES; i++) begin
				meta_array[i] <= '0;
			end
		end else begin
			case (state)
				CS_IDLE: begin
					if (dcache.request) begin
						req_word <= dcache.address[31:2];
						req_rw <= dcache.rw;
						req_wdata <= dcache.wdata;
						scan_index <= '0;
						state <= dcache.flush ? CS_FLUSH_SCAN : CS_LOOKUP;
					end
				end

				CS_LOOKUP: begin
					rdata_q <= data_array[line_index];
					if (hit) begin
						if (req_rw) begin
							data_array[line_index] <= req_wdata;
							meta_array[line_index].dirty <= 1'b1;
						end
						state <= CS_RESPOND;
					end else if (line_meta.valid && line_meta.dirty) begin
						// victim goes back to memory before the refill
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_address <= {line_meta.tag[TAG_BITS-1:0], line_index, 2'b00};
						o_bus_wdata <= data_array[line_index];
						state <= CS_EVICT;
					end else begin
						state <= CS_FILL;
					end
				end

				CS_EVICT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= CS_FILL;
					end
				end

				CS_FILL: begin
					if (!o_bus_request) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b0;
						o_bus_address <= {req_word, 2'b00};
					end else if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						data_array[line_index] <= req_rw ? req_wdata : i_bus_rdata;
						meta_array[line_index] <= '{
							valid: 1'b1,
							dirty: req_rw,
							tag: MAX_TAG_WIDTH'(req_tag)
						};
						rdata_q <= i_bus_rdata;
						state <= CS_RESPOND;
					end
				end

				CS_RESPOND: begin
					state <= CS_IDLE;
				end

				CS_FLUSH_SCAN: begin
					if (scan_meta.valid && scan_meta.dirty) begin
						o_bus_request <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_address <= {scan_meta.tag[TAG_BITS-1:0], scan_index, 2'b00};
						o_bus_wdata <= data_array[scan_index];
						state <= CS_FLUSH_WRITE;
					end else begin
						// clean or empty line, just drop it
						meta_array[scan_index] <= '0;
						scan_index <= scan_index + 1'b1;
						state <= scan_last ? CS_RESPOND : CS_FLUSH_SCAN;
					end
				end

				CS_FLUSH_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						meta_array[scan_index] <= '0;
						scan_index <= scan_index + 1'b1;
						state <= scan_last ? CS_RESPOND : CS_FLUSH_SCAN;
					end
				end

				default: begin
					state <= CS_IDLE;
				end
			endcase
		end
	end

	// a bus transfer holds still until memory accepts it
	a_bus_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=>
			o_bus_request && $stable(o_bus_address) && $stable(o_bus_rw));

	a_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		dcache.ready |-> dcache.request);

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage #(
	parameter int CACHE_LINES = 16
) (
	input logic i_clock,
	input logic i_reset,

	// external bus, driven by the cache
	output logic o_bus_rw,
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata,
	output logic [31:0] o_bus_wdata,

	input logic i_writeback_busy,
	input logic i_execute_valid,
	output logic o_busy,
	output logic o_valid,

	input logic [cpu_types_pkg::TAG_WIDTH-1:0] i_tag,
	output logic [cpu_types_pkg::TAG_WIDTH-1:0] o_tag,

	input logic [4:0] i_inst_rd,
	input logic [31:0] i_rd,
	input logic i_mem_read,
	input logic i_mem_write,
	input logic i_mem_flush,
	input cpu_types_pkg::mem_width_t i_mem_width,
	input logic i_mem_signed,
	input logic [31:0] i_mem_address,

	output logic [4:0] o_inst_rd,
	output logic [31:0] o_rd
);

	import cpu_types_pkg::*;

	dcache_if cache_bus ();

	data_cache #(
		.CACHE_LINES(CACHE_LINES)
	) cache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.dcache(cache_bus),
		.o_bus_rw(o_bus_rw),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.o_bus_wdata(o_bus_wdata)
	);

	mem_state_t state;

	// instruction held for the length of the access
	logic [TAG_WIDTH-1:0] tag_q;
	logic [4:0] inst_rd_q;
	logic [31:0] rd_q;
	mem_width_t width_q;
	logic signed_q;
	logic [31:0] address_q;
	logic [31:0] rmw_word;

	logic accept;
	logic is_memory_op;
	logic finish;
	logic [4:0] lane_shift;
	logic [31:0] shifted_rdata;
	logic [31:0] load_value;
	logic [31:0] lane_mask;
	logic [31:0] merged_word;

	assign accept = (state == ST_IDLE) && i_execute_valid && !i_writeback_busy;
	assign is_memory_op = i_mem_read || i_mem_write || i_mem_flush;
	assign o_busy = (state != ST_IDLE) || i_writeback_busy;

	// rmw read only fetches the old word, the access ends on its write
	assign finish = cache_bus.ready && (state != ST_WRITE_RMW_READ);

	// requests follow the state, so they stay put until ready
	assign cache_bus.request = (state != ST_IDLE);
	assign cache_bus.rw = (state == ST_WRITE_WORD) || (state == ST_WRITE_RMW_WRITE);
	assign cache_bus.flush = (state == ST_FLUSH);
	assign cache_bus.address = {address_q[31:2], 2'b00};
	assign cache_bus.wdata = (state == ST_WRITE_WORD) ? rd_q : merged_word;

	assign lane_shift = {address_q[1:0], 3'b000};
	assign shifted_rdata = cache_bus.rdata >> lane_shift;

	always_comb begin
		case (width_q)
			MEM_BYTE: load_value = {{24{signed_q & shifted_rdata[7]}}, shifted_rdata[7:0]};
			MEM_HALF: load_value = {{16{signed_q & shifted_rdata[15]}}, shifted_rdata[15:0]};
			default: load_value = cache_bus.rdata;
		endcase
	end

	// byte or half lane inserted into the old word
	assign lane_mask = (width_q == MEM_BYTE) ? 32'h0000_00ff : 32'h0000_ffff;
	assign merged_word = (rmw_word & ~(lane_mask << lane_shift)) |
		((rd_q & lane_mask) << lane_shift);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			o_valid <= 1'b0;
		end else begin
			o_valid <= (accept && !is_memory_op) || finish;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						if (i_mem_read) begin
							state <= ST_READ;
						end else if (i_mem_write) begin
							state <= (i_mem_width == MEM_WORD) ? ST_WRITE_WORD : ST_WRITE_RMW_READ;
						end else if (i_mem_flush) begin
							state <= ST_FLUSH;
						end
					end
				end
				ST_WRITE_RMW_READ: begin
					if (cache_bus.ready) begin
						state <= ST_WRITE_RMW_WRITE;
					end
				end
				default: begin
					if (cache_bus.ready) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			tag_q <= i_tag;
			inst_rd_q <= i_inst_rd;
			rd_q <= i_rd;
			width_q <= i_mem_width;
			signed_q <= i_mem_signed;
			address_q <= i_mem_address;
			if (!is_memory_op) begin
				o_tag <= i_tag;
				o_inst_rd <= i_inst_rd;
				o_rd <= i_rd;
			end
		end
		if (state == ST_WRITE_RMW_READ && cache_bus.ready) begin
			rmw_word <= cache_bus.rdata;
		end
		if (finish) begin
			o_tag <= tag_q;
			o_inst_rd <= inst_rd_q;
			o_rd <= (state == ST_READ) ? load_value : rd_q;
		end
	end

	// execute must hand over a known width
	a_width_legal: assert property (@(posedge i_clock) disable iff (i_reset)
		accept && (i_mem_read || i_mem_write) |->
			i_mem_width inside {MEM_BYTE, MEM_HALF, MEM_WORD});

	a_half_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
		accept && (i_mem_read || i_mem_write) && (i_mem_width == MEM_HALF) |->
			!i_mem_address[0]);

	// cache handshake, request and address held until the cache answers
	a_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		cache_bus.request && !cache_bus.ready |=>
			cache_bus.request && $stable(cache_bus.address));

endmodule

/* source/memory_subsystem_top.sv */
`timescale 1ns/1ps

module memory_subsystem_top #(
	parameter int CACHE_LINES = 16
) (
	input logic i_clock,
	input logic i_reset,

	output logic o_bus_rw,
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata,
	output logic [31:0] o_bus_wdata,

	input logic i_writeback_busy,
	input logic i_execute_valid,
	output logic o_busy,
	output logic o_valid,

	input logic [cpu_types_pkg::TAG_WIDTH-1:0] i_tag,
	output logic [cpu_types_pkg::TAG_WIDTH-1:0] o_tag,

	input logic [4:0] i_inst_rd,
	input logic [31:0] i_rd,
	input logic i_mem_read,
	input logic i_mem_write,
	input logic i_mem_flush,
	input cpu_types_pkg::mem_width_t i_mem_width,
	input logic i_mem_signed,
	input logic [31:0] i_mem_address,

	output logic [4:0] o_inst_rd,
	output logic [31:0] o_rd
);

	memory_stage #(
		.CACHE_LINES(CACHE_LINES)
	) stage_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_bus_rw(o_bus_rw),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.o_bus_wdata(o_bus_wdata),
		.i_writeback_busy(i_writeback_busy),
		.i_execute_valid(i_execute_valid),
		.o_busy(o_busy),
		.o_valid(o_valid),
		.i_tag(i_tag),
		.o_tag(o_tag),
		.i_inst_rd(i_inst_rd),
		.i_rd(i_rd),
		.i_mem_read(i_mem_read),
		.i_mem_write(i_mem_write),
		.i_mem_flush(i_mem_flush),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.i_mem_address(i_mem_address),
		.o_inst_rd(o_inst_rd),
		.o_rd(o_rd)
	);

endmodule

/* sim/bus_memory_model.sv */
`timescale 1ns/1ps

module bus_memory_model #(
	parameter int MEM_WORDS = 1024
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [31:0] i_address,
	input logic [31:0] i_wdata,
	output logic o_ready,
	output logic [31:0] o_rdata,
	output int o_protocol_errors
);

	localparam int INDEX_BITS = $clog2(MEM_WORDS);

	logic [31:0] mem [MEM_WORDS];

	logic waiting;
	int unsigned wait_cycles;
	logic held_rw;
	logic [31:0] held_address;
	logic [31:0] held_wdata;

	// every bit of the word index feeds the pattern
	function automatic logic [31:0] fill_word(input int unsigned index);
		return (index * 32'h9e37_79b1) ^ {index[15:0], ~index[15:0]};
	endfunction

	always @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
			waiting <= 1'b0;
			wait_cycles <= 0;
			o_protocol_errors <= 0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= fill_word(i);
			end
		end else if (o_ready) begin
			o_ready <= 1'b0;
			waiting <= 1'b0;
		end else if (waiting) begin
			if (!i_request || i_address != held_address || i_rw != held_rw ||
					(i_rw && i_wdata != held_wdata)) begin
				o_protocol_errors <= o_protocol_errors + 1;
				$display("bus request changed while waiting for ready at %0t", $time);
			end
			if (wait_cycles == 0) begin
				o_ready <= 1'b1;
				if (held_rw) begin
					mem[held_address[INDEX_BITS+1:2]] <= held_wdata;
				end else begin
					o_rdata <= mem[held_address[INDEX_BITS+1:2]];
				end
			end else begin
				wait_cycles <= wait_cycles - 1;
			end
		end else if (i_request) begin
			// new transfer, pick a ready delay of 0 to 3 cycles
			waiting <= 1'b1;
			held_rw <= i_rw;
			held_address <= i_address;
			held_wdata <= i_wdata;
			wait_cycles <= $urandom_range(3, 0);
		end
	end

endmodule

/* sim/tb_memory_subsystem.sv */
`timescale 1ns/1ps

module tb_memory_subsystem;

	import cpu_types_pkg::*;
	import cache_types_pkg::*;

	localparam int CACHE_LINES = 16;
	localparam int MEM_WORDS = 1024;
	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_OPS = 80;
	// flush of 16 dirty lines with slow bus is the longest operation
	localparam int CYCLES_PER_OP = 200;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_OPS * CYCLES_PER_OP;
	localparam logic [31:0] ADDRESS_MASK = 32'h0000_0ffc;

	logic i_clock = 1'b0;
	logic i_reset;
	logic o_bus_rw;
	logic o_bus_request;
	logic i_bus_ready;
	logic [31:0] o_bus_address;
	logic [31:0] i_bus_rdata;
	logic [31:0] o_bus_wdata;
	logic i_writeback_busy;
	logic i_execute_valid;
	logic o_busy;
	logic o_valid;
	logic [TAG_WIDTH-1:0] i_tag;
	logic [TAG_WIDTH-1:0] o_tag;
	logic [4:0] i_inst_rd;
	logic [31:0] i_rd;
	logic i_mem_read;
	logic i_mem_write;
	logic i_mem_flush;
	mem_width_t i_mem_width;
	logic i_mem_signed;
	logic [31:0] i_mem_address;
	logic [4:0] o_inst_rd;
	logic [31:0] o_rd;

	logic [31:0] shadow [MEM_WORDS];
	logic [31:0] written [$];
	logic reloaded [MEM_WORDS];
	logic started;
	logic valid_prev;
	int bus_reads;
	int check_errors;
	int monitor_errors;
	int protocol_errors;

	always #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

	memory_subsystem_top #(
		.CACHE_LINES(CACHE_LINES)
	) dut_i (.*);

	bus_memory_model #(
		.MEM_WORDS(MEM_WORDS)
	) memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(o_bus_request),
		.i_rw(o_bus_rw),
		.i_address(o_bus_address),
		.i_wdata(o_bus_wdata),
		.o_ready(i_bus_ready),
		.o_rdata(i_bus_rdata),
		.o_protocol_errors(protocol_errors)
	);

	function automatic logic [31:0] expected_load(input logic [31:0] address,
			input mem_width_t width, input logic sgn);
		logic [31:0] word;
		logic [7:0] lanes [4];
		int offset;
		word = shadow[address[11:2]];
		offset = int'(address[1:0]);
		for (int b = 0; b < 4; b++) begin
			lanes[b] = word[8*b +: 8];
		end
		case (width)
			MEM_BYTE: return {{24{sgn & lanes[offset][7]}}, lanes[offset]};
			MEM_HALF: return {{16{sgn & lanes[offset+1][7]}}, lanes[offset+1], lanes[offset]};
			default: return word;
		endcase
	endfunction

	function automatic void update_shadow(input logic [31:0] address,
			input mem_width_t width, input logic [31:0] data);
		logic [31:0] word;
		int offset;
		word = shadow[address[11:2]];
		offset = int'(address[1:0]);
		for (int b = 0; b < int'(width); b++) begin
			word[8*(offset+b) +: 8] = data[8*b +: 8];
		end
		shadow[address[11:2]] = word;
	endfunction

	// one instruction through the stage, returns o_rd of its writeback pulse
	task automatic issue(input logic read, input logic write, input logic flush,
			input mem_width_t width, input logic sgn, input logic [31:0] address,
			input logic [31:0] data, output logic [31:0] result);
		logic [TAG_WIDTH-1:0] tag;
		logic [4:0] rd_index;
		int latency;
		tag = TAG_WIDTH'($urandom);
		rd_index = 5'($urandom);
		@(posedge i_clock);
		started = 1'b1;
		i_execute_valid <= 1'b1;
		i_mem_read <= read;
		i_mem_write <= write;
		i_mem_flush <= flush;
		i_mem_width <= width;
		i_mem_signed <= sgn;
		i_mem_address <= address;
		i_rd <= data;
		i_tag <= tag;
		i_inst_rd <= rd_index;
		@(posedge i_clock);
		i_execute_valid <= 1'b0;
		latency = 1;
		@(negedge i_clock);
		while (!o_valid) begin
			@(negedge i_clock);
			latency++;
		end
		assert (o_tag == tag) else begin
			check_errors++;
			$display("MISMATCH o_tag: expected %h got %h", tag, o_tag);
		end
		assert (o_inst_rd == rd_index) else begin
			check_errors++;
			$display("MISMATCH o_inst_rd: expected %h got %h", rd_index, o_inst_rd);
		end
		if (!(read || write || flush)) begin
			assert (latency == 1) else begin
				check_errors++;
				$display("pass-through instruction took %0d cycles instead of 1", latency);
			end
			assert (o_rd == data) else begin
				check_errors++;
				$display("MISMATCH o_rd: expected %h got %h", data, o_rd);
			end
		end
		result = o_rd;
	endtask

	task automatic store(input logic [31:0] address, input mem_width_t width,
			input logic [31:0] data);
		logic [31:0] unused;
		issue(1'b0, 1'b1, 1'b0, width, 1'b0, address, data, unused);
		update_shadow(address, width, data);
		written.push_back({address[31:2], 2'b00});
	endtask

	task automatic load_check(input logic [31:0] address, input mem_width_t width,
			input logic sgn);
		logic [31:0] expected;
		logic [31:0] result;
		expected = expected_load(address, width, sgn);
		issue(1'b1, 1'b0, 1'b0, width, sgn, address, 32'h0, result);
		assert (result == expected) else begin
			check_errors++;
			$display("MISMATCH o_rd at address %h: expected %h got %h", address, expected, result);
		end
	endtask

	task automatic check_cache_empty();
		line_meta_t meta;
		for (int i = 0; i < CACHE_LINES; i++) begin
			meta = dut_i.stage_i.cache_i.meta_array[i];
			assert (!meta.valid) else begin
				check_errors++;
				$display("cache line %0d still valid after flush", i);
			end
		end
	endtask

	// bus traffic and writeback pulse checks
	always @(negedge i_clock) begin
		if (!i_reset) begin
			if (!started) begin
				assert (!o_valid && !o_bus_request) else begin
					monitor_errors++;
					$display("outputs active before the first instruction");
				end
			end
			assert (!(o_valid && valid_prev)) else begin
				monitor_errors++;
				$display("o_valid held high for more than one cycle");
			end
			if (o_bus_request && i_bus_ready) begin
				if (o_bus_rw) begin
					assert (o_bus_wdata == shadow[o_bus_address[11:2]]) else begin
						monitor_errors++;
						$display("MISMATCH o_bus_wdata at address %h: expected %h got %h",
							o_bus_address, shadow[o_bus_address[11:2]], o_bus_wdata);
					end
				end else begin
					bus_reads++;
				end
			end
		end
		valid_prev = o_valid;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("watchdog expired before the tests finished");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic [31:0] address;
		logic [31:0] result;
		logic [TAG_WIDTH-1:0] tag;
		int reads_before;
		void'($urandom(32'h94c7));
		i_reset = 1'b1;
		i_writeback_busy = 1'b0;
		i_execute_valid = 1'b0;
		i_tag = '0;
		i_inst_rd = '0;
		i_rd = '0;
		i_mem_read = 1'b0;
		i_mem_write = 1'b0;
		i_mem_flush = 1'b0;
		i_mem_width = MEM_WORD;
		i_mem_signed = 1'b0;
		i_mem_address = '0;
		started = 1'b0;
		valid_prev = 1'b0;
		bus_reads = 0;
		check_errors = 0;
		monitor_errors = 0;
		repeat (RESET_CYCLES) @(posedge i_clock);
		i_reset <= 1'b0;
		@(negedge i_clock);
		assert (!o_busy) else begin
			check_errors++;
			$display("o_busy high after reset");
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = memory_i.mem[i];
			reloaded[i] = 1'b0;
		end
		repeat (4) @(negedge i_clock);

		repeat (4) issue(1'b0, 1'b0, 1'b0, MEM_WORD, 1'b0, '0, $urandom, result);

		// writeback stalled, instruction must wait
		tag = TAG_WIDTH'($urandom);
		@(posedge i_clock);
		i_writeback_busy <= 1'b1;
		i_execute_valid <= 1'b1;
		i_tag <= tag;
		repeat (5) begin
			@(negedge i_clock);
			assert (o_busy && !o_valid) else begin
				check_errors++;
				$display("instruction accepted while writeback was busy");
			end
		end
		@(posedge i_clock);
		i_writeback_busy <= 1'b0;
		@(posedge i_clock);
		i_execute_valid <= 1'b0;
		@(negedge i_clock);
		assert (o_valid && o_tag == tag) else begin
			check_errors++;
			$display("MISMATCH o_tag after stall: expected %h got %h", tag, o_tag);
		end

		// word stores, runs of three hit the same cache line
		for (int i = 0; i < 12; i++) begin
			if (i % 3 == 0) begin
				address = $urandom & ADDRESS_MASK;
			end else begin
				address = (address + CACHE_LINES * 4) & ADDRESS_MASK;
			end
			store(address, MEM_WORD, $urandom);
		end
		foreach (written[i]) begin
			load_check(written[i], MEM_WORD, 1'b0);
		end
		repeat (4) load_check($urandom & ADDRESS_MASK, MEM_WORD, 1'b0);

		address = $urandom & ADDRESS_MASK;
		for (int offset = 0; offset < 4; offset++) begin
			store(address + offset, MEM_BYTE, $urandom);
		end
		load_check(address, MEM_WORD, 1'b0);
		store(address, MEM_HALF, $urandom);
		store(address + 2, MEM_HALF, $urandom);
		load_check(address, MEM_WORD, 1'b0);

		// mixed sign bits in every byte and half
		address = (address + 4) & ADDRESS_MASK;
		store(address, MEM_WORD, 32'h7a80_f012);
		for (int offset = 0; offset < 4; offset++) begin
			load_check(address + offset, MEM_BYTE, 1'b0);
			load_check(address + offset, MEM_BYTE, 1'b1);
		end
		for (int offset = 0; offset < 4; offset += 2) begin
			load_check(address + offset, MEM_HALF, 1'b0);
			load_check(address + offset, MEM_HALF, 1'b1);
		end

		issue(1'b0, 1'b0, 1'b1, MEM_WORD, 1'b0, '0, '0, result);
		check_cache_empty();
		foreach (written[i]) begin
			if (!reloaded[written[i][11:2]]) begin
				reloaded[written[i][11:2]] = 1'b1;
				reads_before = bus_reads;
				load_check(written[i], MEM_WORD, 1'b0);
				assert (bus_reads > reads_before) else begin
					check_errors++;
					$display("load of %h after flush hit in the cache", written[i]);
				end
			end
		end

		$display("summary: %0d sequence errors, %0d monitor errors, %0d bus protocol errors",
			check_errors, monitor_errors, protocol_errors);
		if (check_errors + monitor_errors + protocol_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* list.f */
source/cpu_types_pkg.sv
source/cache_types_pkg.sv
source/dcache_if.sv
source/data_cache.sv
source/memory_stage.sv
source/memory_subsystem_top.sv
sim/bus_memory_model.sv
sim/tb_memory_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_memory_subsystem

verilator --binary --timing --assert -j 0 --top-module "$TOP" \
	-f list.f -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" "$LOG_FILE"; then
	exit 0
fi
echo "simulation reported failures, see $LOG_FILE"
exit 1
